//--- src/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address word width
`define XLEN 32

// architectural registers, x0 included
`define REG_COUNT 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0060

// byte step between sequential instructions
`define PC_STEP 32'd4

`endif

//--- src/rv32i_isa_pkg.sv
`include "core_cfg.svh"

package rv32i_isa_pkg;

    // one data or address word
    typedef logic [`XLEN-1:0] word_t;

    // register index, 5 bits for 32 registers
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    // major opcodes, only reg/imm/lui are executed
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // arithmetic funct3 field
    typedef enum logic [2:0] {
        add_sub = 3'b000,
        sll     = 3'b001,
        slt     = 3'b010,
        sltu    = 3'b011,
        xor_op  = 3'b100,
        srl_sra = 3'b101,
        or_op   = 3'b110,
        and_op  = 3'b111
    } funct3_e;

endpackage

//--- src/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    // operation carried from decode into execute
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // lui result is the immediate itself
        alu_pass_b = 4'd10
    } alu_op_e;

    // execute operand source
    typedef enum logic {
        from_reg = 1'b0,
        from_wb  = 1'b1
    } fwd_sel_e;

endpackage

//--- src/inst_decoder.sv
`include "core_cfg.svh"

module inst_decoder (
    input  rv32i_isa_pkg::word_t     inst,
    input  logic                     valid,
    output rv32i_isa_pkg::reg_idx_t  rs1,
    output rv32i_isa_pkg::reg_idx_t  rs2,
    output rv32i_isa_pkg::reg_idx_t  rd,
    output rv32i_isa_pkg::word_t     imm,
    output logic                     use_imm,
    output pipe_ctrl_pkg::alu_op_e   alu_op,
    output logic                     reg_write
);

    rv32i_isa_pkg::opcode_e opcode;
    rv32i_isa_pkg::funct3_e funct3;
    logic [6:0]             funct7;
    rv32i_isa_pkg::word_t   i_imm;
    rv32i_isa_pkg::word_t   u_imm;
    logic                   known;

    // fixed field positions of the R/I/U formats
    assign opcode = rv32i_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3 = rv32i_isa_pkg::funct3_e'(inst[14:12]);
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // sign-extended 12-bit and upper 20-bit immediates
    assign i_imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign u_imm = {inst[31:12], {(`XLEN-20){1'b0}}};

    always_comb begin
        known   = 1'b0;
        use_imm = 1'b0;
        imm     = i_imm;
        alu_op  = pipe_ctrl_pkg::alu_add;
        case (opcode)
            rv32i_isa_pkg::op_reg: begin
                // funct7 bit 5 only legal on sub and sra, anything else (mul/div) is rejected
                known = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == rv32i_isa_pkg::add_sub ||
                                                  funct3 == rv32i_isa_pkg::srl_sra));
                case (funct3)
                    rv32i_isa_pkg::add_sub: alu_op = funct7[5] ? pipe_ctrl_pkg::alu_sub
                                                               : pipe_ctrl_pkg::alu_add;
                    rv32i_isa_pkg::sll:     alu_op = pipe_ctrl_pkg::alu_sll;
                    rv32i_isa_pkg::slt:     alu_op = pipe_ctrl_pkg::alu_slt;
                    rv32i_isa_pkg::sltu:    alu_op = pipe_ctrl_pkg::alu_sltu;
                    rv32i_isa_pkg::xor_op:  alu_op = pipe_ctrl_pkg::alu_xor;
                    rv32i_isa_pkg::srl_sra: alu_op = funct7[5] ? pipe_ctrl_pkg::alu_sra
                                                               : pipe_ctrl_pkg::alu_srl;
                    rv32i_isa_pkg::or_op:   alu_op = pipe_ctrl_pkg::alu_or;
                    rv32i_isa_pkg::and_op:  alu_op = pipe_ctrl_pkg::alu_and;
                endcase
            end
            rv32i_isa_pkg::op_imm: begin
                use_imm = 1'b1;
                known   = 1'b1;
                case (funct3)
                    // no subi, the full 12 bits are immediate
                    rv32i_isa_pkg::add_sub: alu_op = pipe_ctrl_pkg::alu_add;
                    rv32i_isa_pkg::sll: begin
                        alu_op = pipe_ctrl_pkg::alu_sll;
                        known  = (funct7 == 7'b0000000);
                    end
                    rv32i_isa_pkg::slt:     alu_op = pipe_ctrl_pkg::alu_slt;
                    rv32i_isa_pkg::sltu:    alu_op = pipe_ctrl_pkg::alu_sltu;
                    rv32i_isa_pkg::xor_op:  alu_op = pipe_ctrl_pkg::alu_xor;
                    rv32i_isa_pkg::srl_sra: begin
                        // srai shares funct7 bit 5 with sra
                        alu_op = funct7[5] ? pipe_ctrl_pkg::alu_sra : pipe_ctrl_pkg::alu_srl;
                        known  = ((funct7 & 7'b1011111) == 7'b0000000);
                    end
                    rv32i_isa_pkg::or_op:   alu_op = pipe_ctrl_pkg::alu_or;
                    rv32i_isa_pkg::and_op:  alu_op = pipe_ctrl_pkg::alu_and;
                endcase
            end
            rv32i_isa_pkg::op_lui: begin
                use_imm = 1'b1;
                imm     = u_imm;
                alu_op  = pipe_ctrl_pkg::alu_pass_b;
                known   = 1'b1;
            end
            default: known = 1'b0;
        endcase
        // bubbles, unknown ops and rd = x0 write nothing and never retire
        reg_write = valid && known && (rd != '0);
    end

endmodule

//--- src/regfile.sv
`include "core_cfg.svh"

module regfile (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     wr_en,
    input  rv32i_isa_pkg::reg_idx_t  wr_idx,
    input  rv32i_isa_pkg::word_t     wr_data,
    input  rv32i_isa_pkg::reg_idx_t  rd_idx_a,
    input  rv32i_isa_pkg::reg_idx_t  rd_idx_b,
    output rv32i_isa_pkg::word_t     rd_data_a,
    output rv32i_isa_pkg::word_t     rd_data_b
);

    rv32i_isa_pkg::word_t regs [`REG_COUNT];
    logic                 wr_live;

    // x0 is never stored to
    assign wr_live = wr_en && (wr_idx != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through, a reader in ID sees the WB value of the same cycle
    assign rd_data_a = (wr_live && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
    assign rd_data_b = (wr_live && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

    // x0 stays zero across every write
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        regs[0] == '0
    );

endmodule

//--- src/alu.sv
`include "core_cfg.svh"

module alu (
    input  pipe_ctrl_pkg::alu_op_e  op,
    input  rv32i_isa_pkg::word_t    a,
    input  rv32i_isa_pkg::word_t    b,
    output rv32i_isa_pkg::word_t    f
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;

    // only the low five bits shift
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            pipe_ctrl_pkg::alu_add:    f = a + b;
            pipe_ctrl_pkg::alu_sub:    f = a - b;
            pipe_ctrl_pkg::alu_sll:    f = a << shamt;
            // compare results are a single lsb
            pipe_ctrl_pkg::alu_slt:    f = rv32i_isa_pkg::word_t'($signed(a) < $signed(b));
            pipe_ctrl_pkg::alu_sltu:   f = rv32i_isa_pkg::word_t'(a < b);
            pipe_ctrl_pkg::alu_xor:    f = a ^ b;
            pipe_ctrl_pkg::alu_srl:    f = a >> shamt;
            // arithmetic, sign bit fills
            pipe_ctrl_pkg::alu_sra:    f = rv32i_isa_pkg::word_t'($signed(a) >>> shamt);
            pipe_ctrl_pkg::alu_or:     f = a | b;
            pipe_ctrl_pkg::alu_and:    f = a & b;
            pipe_ctrl_pkg::alu_pass_b: f = b;
            default:                   f = '0;
        endcase
    end

endmodule

//--- src/forward_unit.sv
module forward_unit (
    input  rv32i_isa_pkg::reg_idx_t  ex_rs1,
    input  rv32i_isa_pkg::reg_idx_t  ex_rs2,
    input  rv32i_isa_pkg::word_t     ex_val_a,
    input  rv32i_isa_pkg::word_t     ex_val_b,
    input  rv32i_isa_pkg::reg_idx_t  wb_rd,
    input  logic                     wb_write,
    input  rv32i_isa_pkg::word_t     wb_data,
    output rv32i_isa_pkg::word_t     op_a,
    output rv32i_isa_pkg::word_t     op_b
);

    pipe_ctrl_pkg::fwd_sel_e sel_a;
    pipe_ctrl_pkg::fwd_sel_e sel_b;

    // WB hit on a nonzero destination that is really written
    function automatic pipe_ctrl_pkg::fwd_sel_e pick(input rv32i_isa_pkg::reg_idx_t src);
        if (wb_write && wb_rd != '0 && wb_rd == src) begin
            return pipe_ctrl_pkg::from_wb;
        end
        return pipe_ctrl_pkg::from_reg;
    endfunction

    // re-evaluated on any WB change too
    always_comb begin
        sel_a = pick(ex_rs1);
        sel_b = pick(ex_rs2);
    end

    // older value captured in ID otherwise
    assign op_a = (sel_a == pipe_ctrl_pkg::from_wb) ? wb_data : ex_val_a;
    assign op_b = (sel_b == pipe_ctrl_pkg::from_wb) ? wb_data : ex_val_b;

endmodule

//--- src/int_pipe_top.sv
`include "core_cfg.svh"

module int_pipe_top (
    input  logic                     clk,
    input  logic                     arst_n,
    output logic                     inst_read,
    output rv32i_isa_pkg::word_t     inst_addr,
    input  logic                     inst_resp,
    input  rv32i_isa_pkg::word_t     inst_rdata,
    output logic                     retire_valid,
    output rv32i_isa_pkg::reg_idx_t  retire_rd,
    output rv32i_isa_pkg::word_t     retire_data
);

    // fetch
    rv32i_isa_pkg::word_t     pc;
    logic                     accept;

    // ID stage
    logic                     id_valid;
    rv32i_isa_pkg::word_t     id_inst;
    rv32i_isa_pkg::reg_idx_t  dec_rs1;
    rv32i_isa_pkg::reg_idx_t  dec_rs2;
    rv32i_isa_pkg::reg_idx_t  dec_rd;
    rv32i_isa_pkg::word_t     dec_imm;
    logic                     dec_use_imm;
    pipe_ctrl_pkg::alu_op_e   dec_alu_op;
    logic                     dec_reg_write;
    rv32i_isa_pkg::word_t     rf_data_a;
    rv32i_isa_pkg::word_t     rf_data_b;

    // EX stage
    logic                     ex_valid;
    rv32i_isa_pkg::reg_idx_t  ex_rs1;
    rv32i_isa_pkg::reg_idx_t  ex_rs2;
    rv32i_isa_pkg::word_t     ex_val_a;
    rv32i_isa_pkg::word_t     ex_val_b;
    rv32i_isa_pkg::word_t     ex_imm;
    logic                     ex_use_imm;
    pipe_ctrl_pkg::alu_op_e   ex_alu_op;
    rv32i_isa_pkg::reg_idx_t  ex_rd;
    logic                     ex_reg_write;
    rv32i_isa_pkg::word_t     fwd_a;
    rv32i_isa_pkg::word_t     fwd_b;
    rv32i_isa_pkg::word_t     alu_b;
    rv32i_isa_pkg::word_t     alu_f;

    // WB stage
    logic                     wb_valid;
    rv32i_isa_pkg::word_t     wb_result;
    rv32i_isa_pkg::reg_idx_t  wb_rd;
    logic                     wb_reg_write;
    logic                     wb_commit;

    // read request rises on the first edge out of reset and stays up
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_read <= 1'b0;
        end else begin
            inst_read <= 1'b1;
        end
    end

    assign inst_addr = pc;
    assign accept    = inst_read && inst_resp;

    // pc only moves on an accepted response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (accept) begin
            pc <= pc + `PC_STEP;
        end
    end

    // no response means a bubble in ID, later stages keep flowing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_inst <= inst_rdata;
        end
    end

    inst_decoder u_dec (
        .inst      (id_inst),
        .valid     (id_valid),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .imm       (dec_imm),
        .use_imm   (dec_use_imm),
        .alu_op    (dec_alu_op),
        .reg_write (dec_reg_write)
    );

    // read in ID, written from WB
    regfile u_rf (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wb_commit),
        .wr_idx    (wb_rd),
        .wr_data   (wb_result),
        .rd_idx_a  (dec_rs1),
        .rd_idx_b  (dec_rs2),
        .rd_data_a (rf_data_a),
        .rd_data_b (rf_data_b)
    );

    // ID/EX control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
        end else begin
            ex_valid     <= id_valid;
            ex_reg_write <= dec_reg_write;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        ex_rs1     <= dec_rs1;
        ex_rs2     <= dec_rs2;
        ex_val_a   <= rf_data_a;
        ex_val_b   <= rf_data_b;
        ex_imm     <= dec_imm;
        ex_use_imm <= dec_use_imm;
        ex_alu_op  <= dec_alu_op;
        ex_rd      <= dec_rd;
    end

    // distance-one dependence, previous instruction sits in WB
    forward_unit u_fwd (
        .ex_rs1   (ex_rs1),
        .ex_rs2   (ex_rs2),
        .ex_val_a (ex_val_a),
        .ex_val_b (ex_val_b),
        .wb_rd    (wb_rd),
        .wb_write (wb_commit),
        .wb_data  (wb_result),
        .op_a     (fwd_a),
        .op_b     (fwd_b)
    );

    // immediate replaces rs2 for op_imm and lui
    assign alu_b = ex_use_imm ? ex_imm : fwd_b;

    alu u_alu (
        .op (ex_alu_op),
        .a  (fwd_a),
        .b  (alu_b),
        .f  (alu_f)
    );

    // EX/WB control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
        end else begin
            wb_valid     <= ex_valid;
            wb_reg_write <= ex_reg_write;
        end
    end

    // EX/WB payload
    always_ff @(posedge clk) begin
        wb_result <= alu_f;
        wb_rd     <= ex_rd;
    end

    // every register write is reported, then lands on the next edge
    assign wb_commit    = wb_valid && wb_reg_write;
    assign retire_valid = wb_commit;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_result;

    // request address holds until the responder answers
    a_addr_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (inst_read && !inst_resp) |=> $stable(inst_addr)
    );

    // pc never leaves word alignment
    a_addr_align: assert property (
        @(posedge clk) disable iff (!arst_n)
        inst_addr[1:0] == 2'b00
    );

endmodule

//--- verif/fetch_responder.sv
`include "core_cfg.svh"

module fetch_responder #(
    parameter int          DEPTH = 64,
    parameter logic [31:0] SEED  = 32'h0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_read,
    input  rv32i_isa_pkg::word_t  inst_addr,
    output logic                  inst_resp,
    output rv32i_isa_pkg::word_t  inst_rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    // program image, written by the testbench before reset ends
    rv32i_isa_pkg::word_t mem [DEPTH];
    int                   prog_len = 0;

    // word index from the reset pc, fill past the end of the program
    function automatic rv32i_isa_pkg::word_t lookup(input rv32i_isa_pkg::word_t addr);
        rv32i_isa_pkg::word_t idx;
        idx = (addr - `RESET_PC) >> 2;
        if (idx < rv32i_isa_pkg::word_t'(prog_len)) begin
            return mem[idx];
        end
        // low 7 bits cleared, opcode 0 decodes to a bubble
        return (addr * 32'h9e37_79b9) & 32'hffff_ff80;
    endfunction

    initial begin
        rv32i_isa_pkg::word_t next_addr;
        // one seed for the whole run
        void'($urandom(SEED));
        inst_resp  = 1'b0;
        inst_rdata = '0;
        forever begin
            @(posedge clk or negedge arst_n);
            if (!arst_n) begin
                inst_resp  <= 1'b0;
                inst_rdata <= lookup(`RESET_PC);
            end else begin
                // address steps only when this edge accepts the response
                next_addr = (inst_read && inst_resp) ? inst_addr + `PC_STEP : inst_addr;
                // roughly one cycle in three is a wait state
                inst_resp  <= ($urandom_range(2, 0) != 0);
                inst_rdata <= lookup(next_addr);
            end
        end
    end

endmodule

//--- verif/int_pipe_tb.sv
`include "core_cfg.svh"

module int_pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 40;
    localparam int TBL_LEN     = 40;
    // worst case 8 cycles per instruction, plus reset and drain
    localparam int WATCHDOG_NS = TBL_LEN * 8 * CLK_PERIOD + 30 * CLK_PERIOD;

    typedef struct packed {
        rv32i_isa_pkg::word_t    inst;
        logic                    retire;
        rv32i_isa_pkg::reg_idx_t rd;
        rv32i_isa_pkg::word_t    value;
    } entry_t;

    typedef struct packed {
        rv32i_isa_pkg::reg_idx_t rd;
        rv32i_isa_pkg::word_t    value;
    } retire_t;

    logic                    clk = 1'b0;
    logic                    arst_n;
    logic                    inst_read;
    rv32i_isa_pkg::word_t    inst_addr;
    logic                    inst_resp;
    rv32i_isa_pkg::word_t    inst_rdata;
    logic                    retire_valid;
    rv32i_isa_pkg::reg_idx_t retire_rd;
    rv32i_isa_pkg::word_t    retire_data;

    // expected fetch request and address
    logic                    exp_read;
    rv32i_isa_pkg::word_t    exp_addr;

    entry_t  tbl [TBL_LEN];
    retire_t pending [$];
    int      value_errors = 0;
    int      other_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    int_pipe_top UUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_read    (inst_read),
        .inst_addr    (inst_addr),
        .inst_resp    (inst_resp),
        .inst_rdata   (inst_rdata),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    fetch_responder #(.DEPTH(64), .SEED(32'h334f_02d1)) imem (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_resp  (inst_resp),
        .inst_rdata (inst_rdata)
    );

    // request goes up on the first edge out of reset
    // address moves one step per answered request
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_read <= 1'b0;
            exp_addr <= `RESET_PC;
        end else begin
            if (exp_read && inst_resp) begin
                exp_addr <= exp_addr + `PC_STEP;
            end
            exp_read <= 1'b1;
        end
    end

    // RV32I R, I and U formats
    function automatic rv32i_isa_pkg::word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
        input rv32i_isa_pkg::reg_idx_t rd, input rv32i_isa_pkg::reg_idx_t rs1,
        input rv32i_isa_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, rv32i_isa_pkg::op_reg};
    endfunction

    function automatic rv32i_isa_pkg::word_t imm_op(input logic [2:0] f3,
        input rv32i_isa_pkg::reg_idx_t rd, input rv32i_isa_pkg::reg_idx_t rs1,
        input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv32i_isa_pkg::op_imm};
    endfunction

    function automatic rv32i_isa_pkg::word_t lui_op(input rv32i_isa_pkg::reg_idx_t rd,
        input logic [19:0] imm);
        return {imm, rd, rv32i_isa_pkg::op_lui};
    endfunction

    // expected values worked out by hand from RV32I semantics
    task automatic fill_table();
        // seed registers x1..x5
        tbl[0]  = '{imm_op(3'd0, 5'd1, 5'd0, 12'h123), 1'b1, 5'd1, 32'h0000_0123};
        tbl[1]  = '{imm_op(3'd0, 5'd2, 5'd0, 12'hffb), 1'b1, 5'd2, 32'hffff_fffb};
        tbl[2]  = '{lui_op(5'd3, 20'h80000), 1'b1, 5'd3, 32'h8000_0000};
        tbl[3]  = '{imm_op(3'd0, 5'd4, 5'd0, 12'h007), 1'b1, 5'd4, 32'h0000_0007};
        tbl[4]  = '{imm_op(3'd0, 5'd5, 5'd0, 12'h7ff), 1'b1, 5'd5, 32'h0000_07ff};
        // register-register ops
        tbl[5]  = '{reg_op(7'h00, 3'd0, 5'd6, 5'd1, 5'd2), 1'b1, 5'd6, 32'h0000_011e};
        tbl[6]  = '{reg_op(7'h20, 3'd0, 5'd7, 5'd1, 5'd2), 1'b1, 5'd7, 32'h0000_0128};
        tbl[7]  = '{reg_op(7'h00, 3'd1, 5'd8, 5'd1, 5'd4), 1'b1, 5'd8, 32'h0000_9180};
        tbl[8]  = '{reg_op(7'h00, 3'd2, 5'd9, 5'd2, 5'd1), 1'b1, 5'd9, 32'h0000_0001};
        tbl[9]  = '{reg_op(7'h00, 3'd3, 5'd10, 5'd2, 5'd1), 1'b1, 5'd10, 32'h0000_0000};
        tbl[10] = '{reg_op(7'h00, 3'd4, 5'd11, 5'd1, 5'd2), 1'b1, 5'd11, 32'hffff_fed8};
        tbl[11] = '{reg_op(7'h00, 3'd5, 5'd12, 5'd3, 5'd4), 1'b1, 5'd12, 32'h0100_0000};
        tbl[12] = '{reg_op(7'h20, 3'd5, 5'd13, 5'd3, 5'd4), 1'b1, 5'd13, 32'hff00_0000};
        tbl[13] = '{reg_op(7'h00, 3'd6, 5'd14, 5'd1, 5'd2), 1'b1, 5'd14, 32'hffff_fffb};
        tbl[14] = '{reg_op(7'h00, 3'd7, 5'd15, 5'd1, 5'd2), 1'b1, 5'd15, 32'h0000_0123};
        // slti, xori, slli, srai
        tbl[15] = '{imm_op(3'd2, 5'd16, 5'd2, 12'hffc), 1'b1, 5'd16, 32'h0000_0001};
        tbl[16] = '{imm_op(3'd4, 5'd17, 5'd1, 12'hfff), 1'b1, 5'd17, 32'hffff_fedc};
        tbl[17] = '{imm_op(3'd1, 5'd18, 5'd4, 12'h01c), 1'b1, 5'd18, 32'h7000_0000};
        tbl[18] = '{imm_op(3'd5, 5'd19, 5'd3, 12'h404), 1'b1, 5'd19, 32'hf800_0000};
        // back to back chain, distance one and two
        tbl[19] = '{imm_op(3'd0, 5'd20, 5'd0, 12'd100), 1'b1, 5'd20, 32'h0000_0064};
        tbl[20] = '{reg_op(7'h00, 3'd0, 5'd21, 5'd20, 5'd20), 1'b1, 5'd21, 32'h0000_00c8};
        tbl[21] = '{reg_op(7'h20, 3'd0, 5'd22, 5'd21, 5'd20), 1'b1, 5'd22, 32'h0000_0064};
        tbl[22] = '{reg_op(7'h00, 3'd4, 5'd23, 5'd22, 5'd21), 1'b1, 5'd23, 32'h0000_00ac};
        // same add with independent work in between
        tbl[23] = '{imm_op(3'd0, 5'd24, 5'd0, 12'd100), 1'b1, 5'd24, 32'h0000_0064};
        tbl[24] = '{imm_op(3'd0, 5'd5, 5'd5, 12'h001), 1'b1, 5'd5, 32'h0000_0800};
        tbl[25] = '{imm_op(3'd0, 5'd6, 5'd6, 12'h001), 1'b1, 5'd6, 32'h0000_011f};
        tbl[26] = '{reg_op(7'h00, 3'd0, 5'd25, 5'd24, 5'd24), 1'b1, 5'd25, 32'h0000_00c8};
        // x0 writes vanish
        tbl[27] = '{imm_op(3'd0, 5'd0, 5'd0, 12'd55), 1'b0, 5'd0, 32'h0};
        tbl[28] = '{reg_op(7'h00, 3'd0, 5'd26, 5'd0, 5'd1), 1'b1, 5'd26, 32'h0000_0123};
        tbl[29] = '{lui_op(5'd0, 20'hfffff), 1'b0, 5'd0, 32'h0};
        tbl[30] = '{reg_op(7'h00, 3'd6, 5'd27, 5'd0, 5'd0), 1'b1, 5'd27, 32'h0000_0000};
        tbl[31] = '{imm_op(3'd0, 5'd28, 5'd0, 12'd9), 1'b1, 5'd28, 32'h0000_0009};
        // lw and mul are not executed, x29 stays zero
        tbl[32] = '{{12'h000, 5'd1, 3'd2, 5'd29, rv32i_isa_pkg::op_load}, 1'b0, 5'd0, 32'h0};
        tbl[33] = '{reg_op(7'h01, 3'd0, 5'd30, 5'd1, 5'd2), 1'b0, 5'd0, 32'h0};
        tbl[34] = '{imm_op(3'd0, 5'd29, 5'd29, 12'h003), 1'b1, 5'd29, 32'h0000_0003};
        tbl[35] = '{reg_op(7'h00, 3'd0, 5'd30, 5'd29, 5'd1), 1'b1, 5'd30, 32'h0000_0126};
        tbl[36] = '{reg_op(7'h00, 3'd3, 5'd31, 5'd0, 5'd30), 1'b1, 5'd31, 32'h0000_0001};
        // shift amount is x2 low five bits, 27
        tbl[37] = '{reg_op(7'h00, 3'd1, 5'd9, 5'd4, 5'd2), 1'b1, 5'd9, 32'h3800_0000};
        tbl[38] = '{{20'h00001, 5'd11, rv32i_isa_pkg::op_auipc}, 1'b0, 5'd0, 32'h0};
        tbl[39] = '{reg_op(7'h00, 3'd0, 5'd12, 5'd11, 5'd0), 1'b1, 5'd12, 32'hffff_fed8};
    endtask

    task automatic compare_word(input string what, input rv32i_isa_pkg::word_t want,
        input rv32i_isa_pkg::word_t got);
        if (got !== want) begin
            $display("Fail %t: %s expected 32'h%08h, got 32'h%08h", $time, what, want, got);
            value_errors++;
        end
    endtask

    task automatic compare_reg_idx(input string what, input rv32i_isa_pkg::reg_idx_t want,
        input rv32i_isa_pkg::reg_idx_t got);
        if (got !== want) begin
            $display("Fail %t: %s expected x%0d, got x%0d", $time, what, want, got);
            value_errors++;
        end
    endtask

    task automatic compare_bit(input string what, input logic want, input logic got);
        if (got !== want) begin
            $display("Fail %t: %s expected %b, got %b", $time, what, want, got);
            value_errors++;
        end
    endtask

    task automatic end_run();
        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // retire outputs are stable mid-cycle
    always @(negedge clk) begin
        retire_t due;
        compare_bit("inst_read", exp_read, inst_read);
        compare_word("inst_addr", exp_addr, inst_addr);
        if (!arst_n) begin
            compare_bit("retire_valid", 1'b0, retire_valid);
        end else if (retire_valid) begin
            if (pending.size() == 0) begin
                $display("%t: x%0d retired with no instruction left to retire", $time, retire_rd);
                other_errors++;
            end else begin
                due = pending.pop_front();
                compare_reg_idx("retire_rd", due.rd, retire_rd);
                compare_word("retire_data", due.value, retire_data);
            end
        end
    end

    initial begin
        retire_t item;
        $timeformat(-9, 1, " ns", 0);
        arst_n = 1'b0;
        fill_table();
        // program image and retire order come from the same table
        for (int i = 0; i < TBL_LEN; i++) begin
            imem.mem[i] = tbl[i].inst;
            if (tbl[i].retire) begin
                item.rd    = tbl[i].rd;
                item.value = tbl[i].value;
                pending.push_back(item);
            end
        end
        imem.prog_len = TBL_LEN;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        while (pending.size() != 0) begin
            @(posedge clk);
        end
        // stay a little longer to catch a duplicate retire
        repeat (10) @(posedge clk);
        end_run();
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: %0d expected retires never arrived", pending.size());
        other_errors++;
        end_run();
    end

endmodule

//--- filelist.f
+incdir+src
src/rv32i_isa_pkg.sv
src/pipe_ctrl_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/alu.sv
src/forward_unit.sv
src/int_pipe_top.sv
verif/fetch_responder.sv
verif/int_pipe_tb.sv

//--- Bender.yml
package:
  name: int_pipe

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv32i_isa_pkg.sv
      - src/pipe_ctrl_pkg.sv
      - src/inst_decoder.sv
      - src/regfile.sv
      - src/alu.sv
      - src/forward_unit.sv
      - src/int_pipe_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/fetch_responder.sv
      - verif/int_pipe_tb.sv
